// ==== commReadout.f ====
hw/commPkg.sv
hw/commRdIf.sv
hw/rdSlotSequencer.sv
hw/wordBuffer.sv
hw/uartTx.sv
hw/commReadout.sv
sim/commReadout_assertions.sv
sim/commReadoutTb.sv

// ==== hw/commPkg.sv ====
package commPkg;

	// Channel count and the number of bytes each channel reads per run
	localparam int CHANNELS = 5;
	localparam int WORDS = 18;

	localparam int ADR_W = 5;
	localparam int DATA_W = 8;
	localparam int CHAN_W = 3;

	// One read slot, in clock cycles, and where the read pulse sits inside it
	localparam int SLOT_CYCLES = 64;
	localparam int RD_START = 40;
	localparam int RD_LEN = 4;

	// Serial line is 8N1, start plus eight data plus stop
	localparam int BIT_CYCLES = 6;
	localparam int FRAME_BITS = 10;

	typedef logic [ADR_W-1:0] adrT;
	typedef logic [DATA_W-1:0] dataT;
	typedef logic [CHAN_W-1:0] chanT;

	// Counter types sized from the timing constants above
	typedef logic [$clog2(SLOT_CYCLES)-1:0] slotCntT;
	typedef logic [$clog2(BIT_CYCLES)-1:0] bitCntT;
	typedef logic [$clog2(FRAME_BITS)-1:0] bitIdxT;

endpackage

// ==== hw/commRdIf.sv ====
`timescale 1ns/1ps

interface commRdIf;
	import commPkg::*;

	// Read request from the sequencer
	logic rd;
	adrT adr;

	// Byte returned by the buffer, valid for one cycle
	dataT data;
	logic dataValid;

	modport seq (
		output rd,
		output adr
	);

	modport buffer (
		input rd,
		input adr,
		output data,
		output dataValid
	);

	modport tx (
		input data,
		input dataValid
	);

endinterface

// ==== hw/commReadout.sv ====
`timescale 1ns/1ps

module commReadout (
	input logic clk,
	input logic rst,
	input logic wrEn,
	input commPkg::chanT wrChan,
	input commPkg::adrT wrAdr,
	input commPkg::dataT wrData,
	input logic [commPkg::CHANNELS-1:0] strob,
	output logic [commPkg::CHANNELS-1:0] txd,
	output logic busy
);
	import commPkg::*;

	logic [CHANNELS-1:0] wrSel;
	logic [CHANNELS-1:0] doneVec;
	logic [CHANNELS-1:0] prevDoneVec;
	logic [CHANNELS-1:0] activeVec;

	// Channel 1 has no predecessor, every other one waits on the one below it
	assign prevDoneVec = {doneVec[CHANNELS-2:0], 1'b1};

	// Busy drops once every sequencer sits in IDLE or HOLD
	assign busy = |activeVec;

	for (genvar ch = 0; ch < CHANNELS; ch++) begin : chan
		commRdIf rdBus ();

		// wrChan counts from 0, the same as the strob and txd bit positions
		assign wrSel[ch] = wrEn && (wrChan == chanT'(ch));

		rdSlotSequencer sequencer (
			.clk(clk),
			.rst(rst),
			.strob(strob[ch]),
			.prevDone(prevDoneVec[ch]),
			.rdPort(rdBus),
			.done(doneVec[ch]),
			.active(activeVec[ch])
		);

		wordBuffer wordBuf (
			.clk(clk),
			.rst(rst),
			.wrEn(wrSel[ch]),
			.wrAdr(wrAdr),
			.wrData(wrData),
			.rdPort(rdBus)
		);

		uartTx transmitter (
			.clk(clk),
			.rst(rst),
			.rdPort(rdBus),
			.txd(txd[ch])
		);
	end

endmodule

// ==== hw/rdSlotSequencer.sv ====
`timescale 1ns/1ps

module rdSlotSequencer (
	input logic clk,
	input logic rst,
	input logic strob,
	input logic prevDone,
	commRdIf.seq rdPort,
	output logic done,
	output logic active
);
	import commPkg::*;

	typedef enum logic [2:0] {
		IDLE,
		WAITPREV,
		SLOT,
		STEP,
		HOLD
	} seqStateT;

	seqStateT state;
	logic [1:0] syncStr;
	logic strobSync;
	slotCntT slotCnt;
	adrT adrCnt;
	logic lastSlot;
	logic lastWord;
	logic inRdWindow;

	// The strobe arrives from the host side with no relation to clk
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			syncStr <= '0;
		end else begin
			syncStr <= {syncStr[0], strob};
		end
	end

	assign strobSync = syncStr[1];

	assign lastSlot = (slotCnt == slotCntT'(SLOT_CYCLES - 1));
	assign lastWord = (adrCnt == adrT'(WORDS - 1));

	// Read pulse covers slot counts 40 to 43
	assign inRdWindow = (slotCnt >= slotCntT'(RD_START)) &&
		(slotCnt < slotCntT'(RD_START + RD_LEN));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (strobSync) begin
						state <= WAITPREV;
					end
				end
				WAITPREV: begin
					// Channel 1 has prevDone tied high and leaves after one cycle
					if (prevDone) begin
						state <= SLOT;
					end
				end
				SLOT: begin
					if (lastSlot) begin
						state <= STEP;
					end
				end
				STEP: begin
					if (lastWord) begin
						done <= 1'b1;
						state <= HOLD;
					end else begin
						state <= SLOT;
					end
				end
				HOLD: begin
					// A strobe left high must drop before another run can start
					if (!strobSync) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Slot counter only runs in SLOT and is back at zero for every new word
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			slotCnt <= '0;
		end else if (state == SLOT) begin
			if (lastSlot) begin
				slotCnt <= '0;
			end else begin
				slotCnt <= slotCnt + 1'b1;
			end
		end
	end

	// Address advances once per word in STEP, wraps to 0 after the last one
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			adrCnt <= '0;
		end else if (state == STEP) begin
			if (lastWord) begin
				adrCnt <= '0;
			end else begin
				adrCnt <= adrCnt + 1'b1;
			end
		end
	end

	assign rdPort.rd = (state == SLOT) && inRdWindow;
	assign rdPort.adr = adrCnt;

	assign active = (state == WAITPREV) || (state == SLOT) || (state == STEP);

endmodule

// ==== hw/uartTx.sv ====
`timescale 1ns/1ps

module uartTx (
	input logic clk,
	input logic rst,
	commRdIf.tx rdPort,
	output logic txd
);
	import commPkg::*;

	// Data bits with the stop bit on top, start bit is driven directly
	logic [FRAME_BITS-2:0] shiftReg;
	bitCntT bitCnt;
	bitIdxT bitIdx;
	logic sending;
	logic bitEnd;
	logic frameEnd;
	logic startFrame;

	assign startFrame = !sending && rdPort.dataValid;
	assign bitEnd = sending && (bitCnt == bitCntT'(BIT_CYCLES - 1));
	assign frameEnd = bitEnd && (bitIdx == bitIdxT'(FRAME_BITS - 1));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sending <= 1'b0;
			bitCnt <= '0;
			bitIdx <= '0;
			txd <= 1'b1;
		end else if (startFrame) begin
			// Start bit goes out on the cycle after dataValid
			sending <= 1'b1;
			bitCnt <= '0;
			bitIdx <= '0;
			txd <= 1'b0;
		end else if (bitEnd) begin
			bitCnt <= '0;
			if (frameEnd) begin
				sending <= 1'b0;
				txd <= 1'b1;
			end else begin
				bitIdx <= bitIdx + 1'b1;
				txd <= shiftReg[0];
			end
		end else if (sending) begin
			bitCnt <= bitCnt + 1'b1;
		end
	end

	// LSB first, ones shift in from the top so the line ends at idle level
	always_ff @(posedge clk) begin
		if (startFrame) begin
			shiftReg <= {1'b1, rdPort.data};
		end else if (bitEnd) begin
			shiftReg <= {1'b1, shiftReg[FRAME_BITS-2:1]};
		end
	end

endmodule

// ==== hw/wordBuffer.sv ====
`timescale 1ns/1ps

module wordBuffer (
	input logic clk,
	input logic rst,
	input logic wrEn,
	input commPkg::adrT wrAdr,
	input commPkg::dataT wrData,
	commRdIf.buffer rdPort
);
	import commPkg::*;

	dataT mem [WORDS];
	dataT dataReg;
	logic validReg;
	logic rdPrev;
	logic rdRise;

	// Writes to addresses past the last word are dropped
	always_ff @(posedge clk) begin
		if (wrEn && (wrAdr < adrT'(WORDS))) begin
			mem[wrAdr] <= wrData;
		end
	end

	// Only the first cycle of the 4-cycle read pulse fetches a byte
	assign rdRise = rdPort.rd && !rdPrev;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rdPrev <= 1'b0;
			validReg <= 1'b0;
		end else begin
			rdPrev <= rdPort.rd;
			validReg <= rdRise;
		end
	end

	always_ff @(posedge clk) begin
		if (rdRise) begin
			dataReg <= mem[rdPort.adr];
		end
	end

	assign rdPort.data = dataReg;
	assign rdPort.dataValid = validReg;

endmodule

// ==== sim/commReadoutTb.sv ====
`timescale 1ns/1ps

module commReadoutTb;
	import commPkg::*;

	localparam int RUN_CYCLES = WORDS * (SLOT_CYCLES + 1);
	localparam int FRAME_CYCLES = FRAME_BITS * BIT_CYCLES;
	// Eleven channel runs over all tests, plus room for writes, waits and settling
	localparam int TOTAL_RUNS = 11;
	localparam int TIMEOUT_CYCLES = TOTAL_RUNS * RUN_CYCLES + 3000;
	// A start bit is first seen one cycle after txd falls
	localparam int MID_OFS = BIT_CYCLES / 2 - 1;

	typedef struct packed {
		chanT ch;
		dataT data;
	} rxItemT;

	logic clk;
	logic rst;
	logic wrEn;
	chanT wrChan;
	adrT wrAdr;
	dataT wrData;
	logic [CHANNELS-1:0] strob;
	logic [CHANNELS-1:0] txd;
	logic busy;

	dataT refMem [CHANNELS][WORDS];
	rxItemT rxQ [$];
	chanT doneOrder [$];
	int cmpCnt [CHANNELS];
	int expCnt [CHANNELS];
	int firstStart [CHANNELS];
	int lastEnd [CHANNELS];
	bit seenStart [CHANNELS];
	bit rxActive [CHANNELS];
	int rxCyc [CHANNELS];
	dataT rxShift [CHANNELS];
	int cycleCnt;
	int errors;
	int checks;
	integer seed;

	commReadout u_dut (
		.clk(clk),
		.rst(rst),
		.wrEn(wrEn),
		.wrChan(wrChan),
		.wrAdr(wrAdr),
		.wrData(wrData),
		.strob(strob),
		.txd(txd),
		.busy(busy)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
	end

	function automatic dataT expectedByte(input int ch, input int idx);
		return refMem[ch][idx];
	endfunction

	task automatic checkByte(input string sig, input dataT exp, input dataT act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected 0x%h, actual 0x%h", sig, exp, act);
		end
	endtask

	task automatic checkChan(input string sig, input chanT exp, input chanT act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected 0x%h, actual 0x%h", sig, exp, act);
		end
	endtask

	task automatic checkLevel(input string sig, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected 0x%h, actual 0x%h", sig, exp, act);
		end
	endtask

	// One 8N1 decoder per txd line, each sampling at mid-bit
	always @(posedge clk) begin
		int bitNo;
		rxItemT newItem;
		for (int ch = 0; ch < CHANNELS; ch++) begin
			if (!rxActive[ch]) begin
				if (rst && !txd[ch]) begin
					rxActive[ch] = 1'b1;
					rxCyc[ch] = 0;
					checkLevel("busy", 1'b1, busy);
					if (!seenStart[ch]) begin
						seenStart[ch] = 1'b1;
						firstStart[ch] = cycleCnt;
					end
				end
			end else begin
				rxCyc[ch]++;
				if ((rxCyc[ch] - MID_OFS) % BIT_CYCLES == 0) begin
					bitNo = (rxCyc[ch] - MID_OFS) / BIT_CYCLES;
					if (bitNo == 0) begin
						if (txd[ch]) begin
							errors++;
							$display("txd[%0d] start bit was too short", ch);
							rxActive[ch] = 1'b0;
						end
					end else if (bitNo <= 8) begin
						rxShift[ch][bitNo-1] = txd[ch];
					end else begin
						if (!txd[ch]) begin
							errors++;
							$display("txd[%0d] frame has no stop bit", ch);
						end
						newItem.ch = chanT'(ch);
						newItem.data = rxShift[ch];
						rxQ.push_back(newItem);
						lastEnd[ch] = cycleCnt;
						rxActive[ch] = 1'b0;
					end
				end
			end
		end
	end

	// Compares every decoded byte with the reference, in arrival order per channel
	always @(posedge clk) begin
		rxItemT item;
		int idx;
		while (rxQ.size() > 0) begin
			item = rxQ.pop_front();
			idx = cmpCnt[item.ch] % WORDS;
			checkByte($sformatf("txd[%0d] byte %0d", item.ch, idx),
				expectedByte(item.ch, idx), item.data);
			cmpCnt[item.ch]++;
			if (cmpCnt[item.ch] % WORDS == 0) begin
				doneOrder.push_back(item.ch);
			end
		end
	end

	task automatic writeByte(input int ch, input int adr, input dataT value);
		@(posedge clk);
		#1;
		wrEn = 1'b1;
		wrChan = chanT'(ch);
		wrAdr = adrT'(adr);
		wrData = value;
		refMem[ch][adr] = value;
		@(posedge clk);
		#1;
		wrEn = 1'b0;
	endtask

	task automatic fillChannel(input int ch);
		for (int a = 0; a < WORDS; a++) begin
			writeByte(ch, a, dataT'($random(seed)));
		end
	endtask

	task automatic setStrob(input int ch, input logic value);
		@(posedge clk);
		#1;
		strob[ch] = value;
	endtask

	task automatic clearRecords();
		doneOrder.delete();
		for (int ch = 0; ch < CHANNELS; ch++) begin
			seenStart[ch] = 1'b0;
		end
	endtask

	task automatic waitFrames();
		bit reached;
		reached = 1'b0;
		while (!reached) begin
			@(posedge clk);
			reached = 1'b1;
			for (int ch = 0; ch < CHANNELS; ch++) begin
				if (cmpCnt[ch] < expCnt[ch]) begin
					reached = 1'b0;
				end
			end
		end
	endtask

	// Lets the last frame finish, then expects a quiet, idle subsystem
	task automatic checkQuiet();
		repeat (FRAME_CYCLES + 8) @(posedge clk);
		#1;
		checkLevel("busy", 1'b0, busy);
		for (int ch = 0; ch < CHANNELS; ch++) begin
			checkLevel($sformatf("txd[%0d]", ch), 1'b1, txd[ch]);
			if (cmpCnt[ch] != expCnt[ch]) begin
				errors++;
				$display("txd[%0d] delivered %0d frames where %0d were expected",
					ch, cmpCnt[ch], expCnt[ch]);
			end
		end
	endtask

	task automatic checkOrder(input int first, input int last);
		if (doneOrder.size() != last - first + 1) begin
			errors++;
			$display("%0d channels completed where %0d were expected",
				doneOrder.size(), last - first + 1);
		end else begin
			for (int i = 0; i <= last - first; i++) begin
				checkChan($sformatf("completion %0d", i), chanT'(first + i), doneOrder[i]);
			end
		end
		for (int ch = first + 1; ch <= last; ch++) begin
			if (firstStart[ch] <= lastEnd[ch-1]) begin
				errors++;
				$display("txd[%0d] started at cycle %0d before txd[%0d] ended at cycle %0d",
					ch, firstStart[ch], ch - 1, lastEnd[ch-1]);
			end
		end
	endtask

	initial begin
		seed = 32'hfe0c_80d2;
		clk = 1'b0;
		rst = 1'b1;
		wrEn = 1'b0;
		wrChan = '0;
		wrAdr = '0;
		wrData = '0;
		strob = '0;
		#1 rst = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b1;
		@(posedge clk);
		#1;
		checkLevel("busy", 1'b0, busy);
		for (int ch = 0; ch < CHANNELS; ch++) begin
			checkLevel($sformatf("txd[%0d]", ch), 1'b1, txd[ch]);
		end

		// Channel 1 alone
		clearRecords();
		fillChannel(0);
		setStrob(0, 1'b1);
		repeat (4) @(posedge clk);
		setStrob(0, 1'b0);
		expCnt[0] += WORDS;
		waitFrames();
		checkQuiet();

		// All five strobes together
		clearRecords();
		for (int ch = 0; ch < CHANNELS; ch++) begin
			fillChannel(ch);
			expCnt[ch] += WORDS;
		end
		@(posedge clk);
		#1 strob = '1;
		waitFrames();
		checkOrder(0, CHANNELS - 1);
		checkQuiet();
		@(posedge clk);
		#1 strob = '0;
		repeat (8) @(posedge clk);

		// Channel 3 armed first has to wait for channels 1 and 2
		clearRecords();
		setStrob(2, 1'b1);
		repeat (4 * SLOT_CYCLES) @(posedge clk);
		if (seenStart[2] || cmpCnt[2] != expCnt[2]) begin
			errors++;
			$display("txd[2] left idle while channel 2 had not run");
		end
		setStrob(0, 1'b1);
		setStrob(1, 1'b1);
		for (int ch = 0; ch < 3; ch++) begin
			expCnt[ch] += WORDS;
		end
		waitFrames();
		checkOrder(0, 2);
		checkQuiet();
		@(posedge clk);
		#1 strob = '0;
		repeat (8) @(posedge clk);

		// Held strobe, then a rewrite and a fresh strobe
		clearRecords();
		setStrob(0, 1'b1);
		expCnt[0] += WORDS;
		waitFrames();
		checkQuiet();
		repeat (3 * SLOT_CYCLES) @(posedge clk);
		checkQuiet();
		writeByte(0, 0, dataT'($random(seed)));
		writeByte(0, 9, dataT'($random(seed)));
		writeByte(0, WORDS - 1, dataT'($random(seed)));
		setStrob(0, 1'b0);
		repeat (8) @(posedge clk);
		setStrob(0, 1'b1);
		expCnt[0] += WORDS;
		waitFrames();
		checkQuiet();
		setStrob(0, 1'b0);

		errors += u_dut.assertChk.failCnt;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		wait (cycleCnt >= TIMEOUT_CYCLES);
		errors++;
		$display("Timeout: frames still missing after %0d cycles", cycleCnt);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("test failed");
		$finish;
	end

endmodule

// ==== sim/commReadout_assertions.sv ====
`timescale 1ns/1ps

module commReadoutAssertions (
	input logic clk,
	input logic rst,
	input logic [commPkg::CHANNELS-1:0] txd,
	input logic busy
);
	import commPkg::*;

	localparam int FRAME_CYCLES = FRAME_BITS * BIT_CYCLES;

	int busyLowCnt;
	int failCnt;

	// Cycles since busy was last high, saturating at one frame time
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busyLowCnt <= 0;
		end else if (busy) begin
			busyLowCnt <= 0;
		end else if (busyLowCnt < FRAME_CYCLES) begin
			busyLowCnt <= busyLowCnt + 1;
		end
	end

	// The last frame of a run ends well inside one frame time after busy drops
	txdIdleWhenQuiet: assert property (@(posedge clk) disable iff (!rst)
		(busyLowCnt >= FRAME_CYCLES) |-> &txd)
		else begin
			failCnt++;
			$error("txd went low after busy had been low for a frame time");
		end

	busyLowAfterReset: assert property (@(posedge clk) $rose(rst) |-> !busy)
		else begin
			failCnt++;
			$error("busy was high in the cycle after reset release");
		end

	txdHighInReset: assert property (@(posedge clk) !rst |-> &txd)
		else begin
			failCnt++;
			$error("txd was not high during reset");
		end

endmodule

bind commReadout commReadoutAssertions assertChk (
	.clk(clk),
	.rst(rst),
	.txd(txd),
	.busy(busy)
);
